// ==== source/audio_dac.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vec_macros.svh"

module audio_dac (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic [`AUDIO_W-1:0] audio,
	output logic                audio_bit
);

	logic [`AUDIO_W-1:0] acc;
	logic [`AUDIO_W:0]   acc_sum;

	assign acc_sum = {1'b0, acc} + {1'b0, audio};

	// the carry rate out of the accumulator is audio / 2**AUDIO_W.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			acc       <= '0;
			audio_bit <= 1'b0;
		end else begin
			acc       <= acc_sum[`AUDIO_W-1:0];
			audio_bit <= acc_sum[`AUDIO_W];
		end
	end

endmodule

`default_nettype wire

// ==== source/cart_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vec_macros.svh"

module cart_arbiter import cart_pkg::*; (
	input  logic               clk_sys,
	input  logic               rst,
	input  logic               ld_wr,
	input  cart_addr_t         ld_addr,
	input  logic [`DATA_W-1:0] ld_data,
	input  logic               con_req,
	input  cart_addr_t         con_addr,
	input  logic [`DATA_W-1:0] mem_rdata,
	output logic               con_grant,
	output logic               rd_done,
	output logic [`DATA_W-1:0] rd_data,
	output mem_op_e            mem_op,
	output cart_addr_t         mem_addr,
	output logic [`DATA_W-1:0] mem_wdata
);

	owner_e owner;
	logic   con_rd_q;

	// the loader always wins, the console only gets a cycle without a write.
	always_comb begin
		owner = own_none;
		if (ld_wr) begin
			owner = own_loader;
		end else if (con_req) begin
			owner = own_console;
		end
	end

	assign con_grant = (owner == own_console);

	always_comb begin
		mem_wdata = ld_data;
		case (owner)
			own_loader: begin
				mem_op   = mem_write;
				mem_addr = ld_addr;
			end
			own_console: begin
				mem_op   = mem_read;
				mem_addr = con_addr;
			end
			default: begin
				mem_op   = mem_idle;
				mem_addr = con_addr;
			end
		endcase
	end

	// a console read returns its byte one clock later.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			con_rd_q <= 1'b0;
		end else begin
			con_rd_q <= (owner == own_console);
		end
	end

	assign rd_done = con_rd_q;
	assign rd_data = mem_rdata;

endmodule

`default_nettype wire

// ==== source/cart_loader.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vec_macros.svh"

module cart_loader import cart_pkg::*; (
	input  logic               clk_sys,
	input  logic               rst,
	input  logic               ioctl_download,
	input  logic               ioctl_wr,
	input  cart_addr_t         ioctl_addr,
	input  logic [`DATA_W-1:0] ioctl_dout,
	input  logic               status_reset,
	output logic               ld_wr,
	output cart_addr_t         ld_addr,
	output logic [`DATA_W-1:0] ld_data,
	output logic               console_reset,
	output logic               led
);

	localparam int HOLD_W = $clog2(`RESET_HOLD + 1);

	logic              dl_fall;
	logic [HOLD_W-1:0] hold_cnt;

	// led is the download level one clock late, so it also marks the falling edge.
	assign dl_fall = led & ~ioctl_download;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ld_wr    <= 1'b0;
			led      <= 1'b0;
			hold_cnt <= '0;
		end else begin
			ld_wr <= ioctl_wr;
			led   <= ioctl_download;
			if (dl_fall) begin
				hold_cnt <= HOLD_W'(`RESET_HOLD);
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		ld_addr <= ioctl_addr;
		ld_data <= ioctl_dout;
	end

	// dl_fall bridges the gap until the counter has been loaded.
	assign console_reset = rst | status_reset | ioctl_download | dl_fall | (hold_cnt != '0);

endmodule

`default_nettype wire

// ==== source/cart_pkg.sv ====
`default_nettype none

`include "vec_macros.svh"

package cart_pkg;

	// operation presented to the cartridge memory in one cycle.
	typedef enum logic [1:0] {
		mem_idle,
		mem_read,
		mem_write
	} mem_op_e;

	// peer that owns the memory port in one cycle.
	typedef enum logic [1:0] {
		own_none,
		own_loader,
		own_console
	} owner_e;

	typedef logic [`CART_AW-1:0] cart_addr_t;

endpackage

`default_nettype wire

// ==== source/cart_port.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vec_macros.svh"

module cart_port import cart_pkg::*; (
	input  logic               clk_sys,
	input  logic               rst,
	input  logic               cart_rd,
	input  cart_addr_t         cart_addr,
	input  logic               con_grant,
	input  logic               rd_done,
	input  logic [`DATA_W-1:0] rd_data,
	output logic               con_req,
	output cart_addr_t         con_addr,
	output logic [`DATA_W-1:0] cart_do,
	output logic               cart_valid
);

	logic               pending;
	cart_addr_t         held_addr;
	logic [`DATA_W-1:0] do_q;

	// a read that loses to a loader write is kept until it gets the memory.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			pending <= 1'b0;
		end else if (con_grant) begin
			pending <= 1'b0;
		end else if (cart_rd) begin
			pending <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_rd) begin
			held_addr <= cart_addr;
		end
		if (rd_done) begin
			do_q <= rd_data;
		end
	end

	assign con_req  = cart_rd | pending;
	assign con_addr = pending ? held_addr : cart_addr;

	// the byte is live in the valid cycle and held from then on.
	assign cart_valid = rd_done;
	assign cart_do    = rd_done ? rd_data : do_q;

endmodule

`default_nettype wire

// ==== source/cart_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vec_macros.svh"

module cart_ram import cart_pkg::*; (
	input  logic               clk_sys,
	input  mem_op_e            mem_op,
	input  cart_addr_t         mem_addr,
	input  logic [`DATA_W-1:0] mem_wdata,
	output logic [`DATA_W-1:0] mem_rdata
);

	localparam int DEPTH = 1 << `CART_AW;

	logic [`DATA_W-1:0] mem [0:DEPTH-1];

	// one port, so a cycle either writes or reads.
	always_ff @(posedge clk_sys) begin
		if (mem_op == mem_write) begin
			mem[mem_addr] <= mem_wdata;
		end else if (mem_op == mem_read) begin
			mem_rdata <= mem[mem_addr]; // valid the cycle after the read.
		end
	end

endmodule

`default_nettype wire

// ==== source/control_mapper.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vec_macros.svh"

module control_mapper import input_pkg::*; (
	input  logic               clk_sys,
	input  logic               rst,
	input  logic [`DATA_W-1:0] joystick_0,
	input  logic [`DATA_W-1:0] joystick_1,
	input  logic [`DATA_W-1:0] kbd_joy,
	output logic [3:0]         buttons,
	output pot_t               pot_x,
	output pot_t               pot_y
);

	logic [`DATA_W-1:0] joy_any;
	pot_t               pot_x_next;
	pot_t               pot_y_next;

	assign joy_any = joystick_0 | joystick_1 | kbd_joy; // any source may press.

	// down and right win over their opposites.
	always_comb begin
		if (joy_any[joy_down]) begin
			pot_y_next = `POT_LOW;
		end else if (joy_any[joy_up]) begin
			pot_y_next = `POT_HIGH;
		end else begin
			pot_y_next = `POT_CENTER;
		end

		if (joy_any[joy_right]) begin
			pot_x_next = `POT_HIGH;
		end else if (joy_any[joy_left]) begin
			pot_x_next = `POT_LOW;
		end else begin
			pot_x_next = `POT_CENTER;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			buttons <= 4'b0000;
			pot_x   <= `POT_CENTER;
			pot_y   <= `POT_CENTER;
		end else begin
			buttons <= {joy_any[joy_btn4], joy_any[joy_btn3], joy_any[joy_btn2], joy_any[joy_btn1]};
			pot_x   <= pot_x_next;
			pot_y   <= pot_y_next;
		end
	end

endmodule

`default_nettype wire

// ==== source/input_pkg.sv ====
`default_nettype none

package input_pkg;

	// bit positions inside a joystick word, shared by the host joysticks and the keyboard.
	typedef enum logic [2:0] {
		joy_right = 3'd0,
		joy_left  = 3'd1,
		joy_down  = 3'd2,
		joy_up    = 3'd3,
		joy_btn1  = 3'd4,
		joy_btn2  = 3'd5,
		joy_btn3  = 3'd6,
		joy_btn4  = 3'd7
	} joy_bit_e;

	// two's complement pot value, 8'h7F is full up or right.
	typedef logic signed [7:0] pot_t;

endpackage

`default_nettype wire

// ==== source/vec_macros.svh ====
`ifndef VEC_MACROS_SVH
`define VEC_MACROS_SVH

// cartridge space is 32 KiB of bytes.
`define CART_AW 15
`define DATA_W 8

// the console delivers a 10-bit unsigned audio sample.
`define AUDIO_W 10

// analogue pot levels seen by the console for a digital stick.
`define POT_CENTER 8'h00
`define POT_HIGH 8'h7F
`define POT_LOW 8'h80

// console reset is stretched this many clocks past the end of a download.
`define RESET_HOLD 16

`endif

// ==== source/vectrex_board.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vec_macros.svh"

module vectrex_board import cart_pkg::*, input_pkg::*; (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                ioctl_download,
	input  logic                ioctl_wr,
	input  cart_addr_t          ioctl_addr,
	input  logic [`DATA_W-1:0]  ioctl_dout,
	input  logic                status_reset,
	input  logic                cart_rd,
	input  cart_addr_t          cart_addr,
	input  logic [`DATA_W-1:0]  joystick_0,
	input  logic [`DATA_W-1:0]  joystick_1,
	input  logic [`DATA_W-1:0]  kbd_joy,
	input  logic [`AUDIO_W-1:0] audio,
	output logic [`DATA_W-1:0]  cart_do,
	output logic                cart_valid,
	output logic                console_reset,
	output logic                led,
	output logic [3:0]          buttons,
	output pot_t                pot_x,
	output pot_t                pot_y,
	output logic                audio_l,
	output logic                audio_r
);

	logic               ld_wr;
	cart_addr_t         ld_addr;
	logic [`DATA_W-1:0] ld_data;
	logic               con_req;
	cart_addr_t         con_addr;
	logic               con_grant;
	logic               rd_done;
	logic [`DATA_W-1:0] rd_data;
	mem_op_e            mem_op;
	cart_addr_t         mem_addr;
	logic [`DATA_W-1:0] mem_wdata;
	logic [`DATA_W-1:0] mem_rdata;

	cart_loader cart_loader (
		.clk_sys        ( clk_sys        ),
		.rst            ( rst            ),
		.ioctl_download ( ioctl_download ),
		.ioctl_wr       ( ioctl_wr       ),
		.ioctl_addr     ( ioctl_addr     ),
		.ioctl_dout     ( ioctl_dout     ),
		.status_reset   ( status_reset   ),
		.ld_wr          ( ld_wr          ),
		.ld_addr        ( ld_addr        ),
		.ld_data        ( ld_data        ),
		.console_reset  ( console_reset  ),
		.led            ( led            )
	);

	cart_port cart_port (
		.clk_sys    ( clk_sys    ),
		.rst        ( rst        ),
		.cart_rd    ( cart_rd    ),
		.cart_addr  ( cart_addr  ),
		.con_grant  ( con_grant  ),
		.rd_done    ( rd_done    ),
		.rd_data    ( rd_data    ),
		.con_req    ( con_req    ),
		.con_addr   ( con_addr   ),
		.cart_do    ( cart_do    ),
		.cart_valid ( cart_valid )
	);

	cart_arbiter cart_arbiter (
		.clk_sys   ( clk_sys   ),
		.rst       ( rst       ),
		.ld_wr     ( ld_wr     ),
		.ld_addr   ( ld_addr   ),
		.ld_data   ( ld_data   ),
		.con_req   ( con_req   ),
		.con_addr  ( con_addr  ),
		.mem_rdata ( mem_rdata ),
		.con_grant ( con_grant ),
		.rd_done   ( rd_done   ),
		.rd_data   ( rd_data   ),
		.mem_op    ( mem_op    ),
		.mem_addr  ( mem_addr  ),
		.mem_wdata ( mem_wdata )
	);

	cart_ram cart_ram (
		.clk_sys   ( clk_sys   ),
		.mem_op    ( mem_op    ),
		.mem_addr  ( mem_addr  ),
		.mem_wdata ( mem_wdata ),
		.mem_rdata ( mem_rdata )
	);

	control_mapper control_mapper (
		.clk_sys    ( clk_sys    ),
		.rst        ( rst        ),
		.joystick_0 ( joystick_0 ),
		.joystick_1 ( joystick_1 ),
		.kbd_joy    ( kbd_joy    ),
		.buttons    ( buttons    ),
		.pot_x      ( pot_x      ),
		.pot_y      ( pot_y      )
	);

	audio_dac audio_dac (
		.clk_sys   ( clk_sys ),
		.rst       ( rst     ),
		.audio     ( audio   ),
		.audio_bit ( audio_l )
	);

	assign audio_r = audio_l; // mono source on both channels.

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+source
source/cart_pkg.sv
source/input_pkg.sv
source/cart_ram.sv
source/cart_arbiter.sv
source/cart_loader.sv
source/cart_port.sv
source/control_mapper.sv
source/audio_dac.sv
source/vectrex_board.sv
test/tb_vectrex_board.sv

// ==== test/tb_vectrex_board.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vec_macros.svh"

module tb_vectrex_board import cart_pkg::*, input_pkg::*; ();

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_BYTES    = 64;
	localparam int NUM_PLAIN    = 8;
	localparam int NUM_COLLIDE  = 16;
	localparam int MAX_WR       = 4;
	localparam int READ_SLOTS   = MAX_WR + 8; // one read with its write burst fits here.
	localparam int NUM_MAP      = 40;
	localparam int NUM_SAMPLES  = 6;
	localparam int RUN_CYCLES   = RESET_CYCLES + NUM_BYTES * 2 + 4
		+ (NUM_BYTES + NUM_PLAIN + NUM_COLLIDE) * READ_SLOTS
		+ 3 * `RESET_HOLD + 16 + 2 * (NUM_MAP + 4) + NUM_SAMPLES * 1025;
	localparam int WATCHDOG_NS  = (RUN_CYCLES + 256) * CLK_PERIOD;
	localparam cart_addr_t FAR_BIT = cart_addr_t'(1) << (`CART_AW - 1);

	logic                clk_sys = 1'b0;
	logic                rst;
	logic                ioctl_download;
	logic                ioctl_wr;
	cart_addr_t          ioctl_addr;
	logic [`DATA_W-1:0]  ioctl_dout;
	logic                status_reset;
	logic                cart_rd;
	cart_addr_t          cart_addr;
	logic [`DATA_W-1:0]  joystick_0;
	logic [`DATA_W-1:0]  joystick_1;
	logic [`DATA_W-1:0]  kbd_joy;
	logic [`AUDIO_W-1:0] audio;
	logic [`DATA_W-1:0]  cart_do;
	logic                cart_valid;
	logic                console_reset;
	logic                led;
	logic [3:0]          buttons;
	pot_t                pot_x;
	pot_t                pot_y;
	logic                audio_l;
	logic                audio_r;

	integer             seed = 32'h6b414b57;
	int                 error_count = 0;
	int                 check_count = 0;
	int                 first_error;
	int                 i;
	logic [`DATA_W-1:0] mem_model [0:(1 << `CART_AW)-1];
	cart_addr_t         addr_list [$];

	vectrex_board i_vectrex_board (
		.clk_sys        ( clk_sys        ),
		.rst            ( rst            ),
		.ioctl_download ( ioctl_download ),
		.ioctl_wr       ( ioctl_wr       ),
		.ioctl_addr     ( ioctl_addr     ),
		.ioctl_dout     ( ioctl_dout     ),
		.status_reset   ( status_reset   ),
		.cart_rd        ( cart_rd        ),
		.cart_addr      ( cart_addr      ),
		.joystick_0     ( joystick_0     ),
		.joystick_1     ( joystick_1     ),
		.kbd_joy        ( kbd_joy        ),
		.audio          ( audio          ),
		.cart_do        ( cart_do        ),
		.cart_valid     ( cart_valid     ),
		.console_reset  ( console_reset  ),
		.led            ( led            ),
		.buttons        ( buttons        ),
		.pot_x          ( pot_x          ),
		.pot_y          ( pot_y          ),
		.audio_l        ( audio_l        ),
		.audio_r        ( audio_r        )
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("*** FAILED ***");
		$finish;
	end

	// both audio channels carry the same bit in every cycle.
	always @(negedge clk_sys) begin
		if (!rst) begin
			assert (audio_r === audio_l) else begin
				$display("Error: audio_r = %h, expected %h", audio_r, audio_l);
				error_count++;
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			$display("Error: %s = %h, expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		check_count++;
		assert (cond) else begin
			$display("%s", what);
			error_count++;
		end
	endtask

	task automatic report_test(input int num, input string name);
		$display("test %0d %s: %0d errors", num, name, error_count - first_error);
		first_error = error_count;
	endtask

	function automatic pot_t expect_pot_x(input logic [`DATA_W-1:0] any);
		if (any[joy_right]) begin
			return `POT_HIGH;
		end else if (any[joy_left]) begin
			return `POT_LOW;
		end
		return `POT_CENTER;
	endfunction

	function automatic pot_t expect_pot_y(input logic [`DATA_W-1:0] any);
		if (any[joy_down]) begin
			return `POT_LOW;
		end else if (any[joy_up]) begin
			return `POT_HIGH;
		end
		return `POT_CENTER;
	endfunction

	task automatic download_bytes(input int count);
		cart_addr_t         addr;
		logic [`DATA_W-1:0] data;
		@(negedge clk_sys);
		ioctl_download = 1'b1;
		repeat (count) begin
			@(negedge clk_sys);
			addr = cart_addr_t'($random(seed));
			data = 8'($random(seed));
			ioctl_wr = 1'b1;
			ioctl_addr = addr;
			ioctl_dout = data;
			mem_model[addr] = data;
			addr_list.push_back(addr);
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
		end
		@(negedge clk_sys);
		ioctl_download = 1'b0;
	endtask

	// nwr write strobes start one cycle ahead of the read, so ld_wr blocks it nwr cycles.
	task automatic read_and_check(input cart_addr_t addr, input int nwr);
		int                 cyc;
		int                 pulses;
		int                 lat;
		logic [`DATA_W-1:0] got;
		cart_addr_t         waddr;
		logic [`DATA_W-1:0] wdata;
		pulses = 0;
		lat = 0;
		got = '0;
		for (cyc = 0; cyc < READ_SLOTS; cyc++) begin
			@(negedge clk_sys);
			if (cart_valid) begin
				pulses++;
				if (pulses == 1) begin
					lat = cyc - 1;
					got = cart_do;
				end
			end
			ioctl_wr = (cyc < nwr);
			if (cyc < nwr) begin
				waddr = addr ^ FAR_BIT ^ cart_addr_t'(cyc); // never the address being read.
				wdata = 8'($random(seed));
				ioctl_addr = waddr;
				ioctl_dout = wdata;
				mem_model[waddr] = wdata;
			end
			cart_rd = (cyc == 1);
			cart_addr = (cyc == 1) ? addr : ~addr; // the address is only valid with the strobe.
		end
		check_true(pulses == 1, "cart_valid did not pulse exactly once for a read");
		if (pulses >= 1) begin
			check_value("cart_valid latency", lat, nwr + 1);
			check_value("cart_do", got, mem_model[addr]);
		end
	endtask

	task automatic apply_and_check_controls(input logic [7:0] j0, input logic [7:0] j1,
			input logic [7:0] kbd);
		logic [`DATA_W-1:0] any;
		logic [`DATA_W-1:0] prev;
		any = j0 | j1 | kbd;
		@(negedge clk_sys);
		prev = joystick_0 | joystick_1 | kbd_joy;
		joystick_0 = j0;
		joystick_1 = j1;
		kbd_joy = kbd;
		#(CLK_PERIOD / 4); // the registered outputs still show the previous words.
		check_value("pot_x", pot_x, expect_pot_x(prev));
		check_value("pot_y", pot_y, expect_pot_y(prev));
		check_value("buttons", buttons, prev[7:4]);
		@(negedge clk_sys);
		check_value("pot_x", pot_x, expect_pot_x(any));
		check_value("pot_y", pot_y, expect_pot_y(any));
		check_value("buttons", buttons, any[7:4]);
	endtask

	task automatic audio_density(input logic [`AUDIO_W-1:0] sample);
		int ones;
		ones = 0;
		@(negedge clk_sys);
		audio = sample;
		repeat (1 << `AUDIO_W) begin
			@(negedge clk_sys);
			ones += audio_l;
		end
		check_value("audio_l ones", ones, sample);
	endtask

	task automatic run_reset_test();
		int k;
		@(negedge clk_sys);
		check_value("console_reset", console_reset, 0);
		status_reset = 1'b1;
		@(negedge clk_sys);
		check_value("console_reset", console_reset, 1);
		status_reset = 1'b0;
		@(negedge clk_sys);
		check_value("console_reset", console_reset, 0);
		check_value("led", led, 0);
		ioctl_download = 1'b1;
		#(CLK_PERIOD / 4); // led only follows at the next clock.
		check_value("led", led, 0);
		repeat (5) begin
			@(negedge clk_sys);
			check_value("console_reset", console_reset, 1);
			check_value("led", led, 1);
		end
		ioctl_download = 1'b0;
		#(CLK_PERIOD / 4);
		check_value("led", led, 1);
		check_value("console_reset", console_reset, 1);
		// the hold counter loads on the first clock that sees the download low.
		for (k = 1; k <= `RESET_HOLD + 1; k++) begin
			@(negedge clk_sys);
			check_value("console_reset", console_reset, (k <= `RESET_HOLD));
			if (k == 1) begin
				check_value("led", led, 0);
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		status_reset = 1'b0;
		cart_rd = 1'b0;
		cart_addr = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		kbd_joy = '0;
		audio = '0;
		repeat (RESET_CYCLES) begin
			@(negedge clk_sys);
			check_value("console_reset", console_reset, 1);
			check_value("cart_valid", cart_valid, 0);
			check_value("audio_l", audio_l, 0);
			check_value("pot_x", pot_x, `POT_CENTER);
			check_value("pot_y", pot_y, `POT_CENTER);
			check_value("buttons", buttons, 0);
		end
		rst = 1'b0;
		first_error = error_count;

		download_bytes(NUM_BYTES);
		foreach (addr_list[n]) begin
			read_and_check(addr_list[n], 0);
		end
		report_test(1, "download and read-back");

		for (i = 0; i < NUM_PLAIN; i++) begin
			read_and_check(addr_list[i], 0);
		end
		for (i = 0; i < NUM_COLLIDE; i++) begin
			read_and_check(addr_list[NUM_PLAIN + i], 1 + (i % MAX_WR));
		end
		report_test(2, "read latency and back-pressure");

		run_reset_test();
		report_test(3, "console reset");

		apply_and_check_controls(8'h00, 8'h00, 8'h00);
		apply_and_check_controls(8'h0C, 8'h00, 8'h00); // up and down together.
		apply_and_check_controls(8'h00, 8'h02, 8'h01); // left and right from two sources.
		apply_and_check_controls(8'h10, 8'h20, 8'hC0);
		for (i = 0; i < NUM_MAP; i++) begin
			apply_and_check_controls(8'($random(seed)), 8'($random(seed)), 8'($random(seed)));
		end
		report_test(4, "control mapping");

		audio_density(10'd0);
		audio_density(10'd1);
		audio_density(10'd341);
		audio_density(10'd512);
		audio_density(10'd1000);
		audio_density(10'd1023);
		report_test(5, "audio density");

		$display("tests 5, checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
